// ==== common/vfu_settings.svh ====
/*
  Build-time sizing of the vector functional unit.
  Lanes are fixed at 32 bits, and element widths of 8, 16 and 32 are supported.
  VFU_WORDS_PER_VREG must be a power of two of at least 2.
*/

`ifndef VFU_SETTINGS_SVH
`define VFU_SETTINGS_SVH

// Number of 32-bit integer lanes, one register file word spans all of them
`define VFU_N_LANES 2

// Lane width in bits
`define VFU_ELEN 32

// Vector register file geometry
`define VFU_NR_VREGS 32
`define VFU_WORDS_PER_VREG 4

`endif

// ==== common/vfu_pkg.sv ====
/*
  Shared types of the vector functional unit.
  Widths follow the macros in vfu_settings.svh.
  Element width codes are log2 of the element size in bytes.
*/

`include "vfu_settings.svh"

package vfu_pkg;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  typedef enum logic [2:0] {
    VADD = 3'd0,
    VSUB = 3'd1,
    VAND = 3'd2,
    VOR  = 3'd3,
    VXOR = 3'd4,
    VMIN = 3'd5,
    VMAX = 3'd6
  } vfu_op_e;

  typedef logic [1:0] vfu_id_t;

  typedef logic [$clog2(`VFU_NR_VREGS*`VFU_WORDS_PER_VREG)-1:0] vreg_addr_t;
  typedef logic [`VFU_N_LANES*`VFU_ELEN-1:0]                    vreg_data_t;
  typedef logic [`VFU_N_LANES*`VFU_ELEN/8-1:0]                  vreg_be_t;

  // Holds the full element count of one register at 8-bit elements
  typedef logic [$clog2(`VFU_WORDS_PER_VREG*`VFU_N_LANES*`VFU_ELEN/8):0] vlen_t;

  typedef struct packed {
    vfu_id_t                           id;
    vfu_op_e                           op;
    vew_e                              vsew;
    vlen_t                             vl;
    logic [$clog2(`VFU_NR_VREGS)-1:0]  vd;
    logic [$clog2(`VFU_NR_VREGS)-1:0]  vs1;
    logic [$clog2(`VFU_NR_VREGS)-1:0]  vs2;
    logic [31:0]                       rs1;
    logic [31:0]                       rs2;
    logic                              use_vs1;
    logic                              is_scalar;
    logic [4:0]                        rd;
  } vfu_req_t;

  // Travels with every word from issue to writeback
  typedef struct packed {
    vfu_id_t    id;
    logic [4:0] rd;
    vreg_addr_t vd_addr;
    vreg_be_t   be;
    logic       wb;
    logic       last;
  } vfu_tag_t;

  typedef struct packed {
    vfu_id_t     id;
    logic [4:0]  rd;
    logic        wb;
    logic [31:0] result;
  } vfu_rsp_t;

  typedef struct packed {
    vreg_data_t result;
    vfu_tag_t   tag;
  } lane_result_t;

endpackage

// ==== common/vfu_if.sv ====
/*
  Word-level links inside the vector functional unit.
  Both follow valid/ready, and a raised valid holds with its payload
  until the transfer.
*/

`timescale 1ns/100ps

// Controller to lanes, one operand word per transfer
interface vfu_issue_if;
  logic                 valid;
  logic                 ready;
  vfu_pkg::vfu_op_e     op;
  vfu_pkg::vew_e        vsew;
  vfu_pkg::vreg_data_t  op1;
  vfu_pkg::vreg_data_t  op2;
  vfu_pkg::vfu_tag_t    tag;

  modport issue (output valid, op, vsew, op1, op2, tag, input ready);
  modport lane  (input valid, op, vsew, op1, op2, tag, output ready);
endinterface

// Lanes to writeback, one result word per transfer
interface vfu_result_if;
  logic                 valid;
  logic                 ready;
  vfu_pkg::vreg_data_t  result;
  vfu_pkg::vfu_tag_t    tag;

  modport source (output valid, result, tag, input ready);
  modport sink   (input valid, result, tag, output ready);
endinterface

// ==== design/spill_register.sv ====
/*
  Two-slot elastic buffer, in order, full throughput.
  ready_o depends on internal state only, so it breaks the ready path.
  Payload slots carry no reset.
*/

`timescale 1ns/100ps

module spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Slot a takes new data, slot b holds the older word when the sink stalls
  logic a_full_q, b_full_q;
  T     a_data_q, b_data_q;
  logic a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  stable_out: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

// ==== int_lanes/int_lanes.sv ====
/*
  Integer lane slices and the result buffer.
  Lanes are 32 bits wide; add and sub wrap, min and max are signed.
  Every slice works on every word, and writeback picks lane 0 for scalars.
*/

`timescale 1ns/100ps
`include "vfu_settings.svh"

module int_lanes (
  input  logic          clk_i,
  input  logic          rst_n_i,
  vfu_issue_if.lane     issue,
  vfu_result_if.source  result
);

  localparam int unsigned ELEN = `VFU_ELEN;

  typedef logic signed [ELEN-1:0] elem_t;

  vfu_pkg::vreg_data_t   lane_word;
  vfu_pkg::lane_result_t lane_in;
  vfu_pkg::lane_result_t lane_out;

  // Operands arrive sign extended, so narrow results are the low bits
  function automatic logic [ELEN-1:0] alu_op(vfu_pkg::vfu_op_e op, elem_t a, elem_t b);
    logic [ELEN-1:0] res;
    unique case (op)
      vfu_pkg::VADD: res = a + b;
      vfu_pkg::VSUB: res = a - b;
      vfu_pkg::VAND: res = a & b;
      vfu_pkg::VOR:  res = a | b;
      vfu_pkg::VXOR: res = a ^ b;
      vfu_pkg::VMIN: res = (a < b) ? a : b;
      vfu_pkg::VMAX: res = (a > b) ? a : b;
      default:       res = '0;
    endcase
    return res;
  endfunction

  ////////////////////////////////////////
  // Lane slices
  ////////////////////////////////////////

  for (genvar l = 0; l < `VFU_N_LANES; l++) begin : gen_lane
    logic [ELEN-1:0] a, b;
    logic [ELEN-1:0] res_8, res_16, res_32;

    assign a = issue.op1[l*ELEN +: ELEN];
    assign b = issue.op2[l*ELEN +: ELEN];

    always_comb begin
      for (int e = 0; e < ELEN / 8; e++) begin
        res_8[e*8 +: 8] = 8'(alu_op(issue.op, elem_t'(signed'(a[e*8 +: 8])),
                                    elem_t'(signed'(b[e*8 +: 8]))));
      end
      for (int e = 0; e < ELEN / 16; e++) begin
        res_16[e*16 +: 16] = 16'(alu_op(issue.op, elem_t'(signed'(a[e*16 +: 16])),
                                        elem_t'(signed'(b[e*16 +: 16]))));
      end
      res_32 = alu_op(issue.op, signed'(a), signed'(b));
    end

    always_comb begin
      unique case (issue.vsew)
        vfu_pkg::EW_8:  lane_word[l*ELEN +: ELEN] = res_8;
        vfu_pkg::EW_16: lane_word[l*ELEN +: ELEN] = res_16;
        default:        lane_word[l*ELEN +: ELEN] = res_32;
      endcase
    end
  end

  ////////////////////////////////////////
  // Result buffer
  ////////////////////////////////////////

  assign lane_in.result = lane_word;
  assign lane_in.tag    = issue.tag;

  spill_register #(
    .T(vfu_pkg::lane_result_t)
  ) i_result_buf (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(issue.valid),
    .ready_o(issue.ready),
    .data_i (lane_in),
    .valid_o(result.valid),
    .ready_i(result.ready),
    .data_o (lane_out)
  );

  assign result.result = lane_out.result;
  assign result.tag    = lane_out.tag;

endmodule

// ==== design/vfu_controller.sv ====
/*
  Walks the words of the request at the queue head and issues operand words.
  vl must be nonzero and fit in one register.
  Scalar requests issue a single word and read nothing.
*/

`timescale 1ns/100ps
`include "vfu_settings.svh"

module vfu_controller (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  vfu_pkg::vfu_req_t         req_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  output vfu_pkg::vreg_addr_t [1:0] vrf_raddr_o,
  output logic                [1:0] vrf_re_o,
  input  vfu_pkg::vreg_data_t [1:0] vrf_rdata_i,
  input  logic                [1:0] vrf_rvalid_i,
  vfu_issue_if.issue                issue
);

  localparam int unsigned WPR     = `VFU_WORDS_PER_VREG;
  localparam int unsigned BPW     = `VFU_N_LANES * `VFU_ELEN / 8;
  localparam int unsigned BPW_LOG = $clog2(BPW);
  localparam int unsigned CNT_W   = $clog2(WPR);
  localparam int unsigned BYTES_W = $bits(vfu_pkg::vlen_t) + 2;

  logic [CNT_W-1:0]   word_cnt_q;
  logic [BYTES_W-1:0] total_bytes;
  logic [BYTES_W-1:0] last_word_idx;
  logic [BPW_LOG-1:0] tail_bytes;
  vfu_pkg::vreg_be_t  tail_be;
  logic               last_word;
  logic               operands_ready;
  logic               word_issue;

  ////////////////////////////////////////
  // Word sequencing
  ////////////////////////////////////////

  assign total_bytes   = BYTES_W'(req_i.vl) << req_i.vsew;
  assign last_word_idx = (total_bytes - 1'b1) >> BPW_LOG;
  assign tail_bytes    = total_bytes[BPW_LOG-1:0];
  // A tail of zero bytes means the last word is full
  assign tail_be       = (tail_bytes == '0) ? '1 : ~(vfu_pkg::vreg_be_t'('1) << tail_bytes);
  assign last_word     = req_i.is_scalar || (BYTES_W'(word_cnt_q) == last_word_idx);

  assign operands_ready = req_valid_i &&
                          (req_i.is_scalar ||
                           (vrf_rvalid_i[0] && (!req_i.use_vs1 || vrf_rvalid_i[1])));

  // Valid goes up only in the cycle of transfer,
  // since the register file may drop rvalid while the lanes stall
  assign word_issue  = operands_ready && issue.ready;
  assign issue.valid = word_issue;

  // Pop the request together with its last word
  assign req_ready_o = word_issue && last_word;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      word_cnt_q <= '0;
    end else if (word_issue) begin
      word_cnt_q <= last_word ? '0 : word_cnt_q + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Register file reads
  ////////////////////////////////////////

  assign vrf_re_o[0] = req_valid_i && !req_i.is_scalar;
  assign vrf_re_o[1] = req_valid_i && !req_i.is_scalar && req_i.use_vs1;

  assign vrf_raddr_o[0] = vfu_pkg::vreg_addr_t'(req_i.vs2 * WPR + word_cnt_q);
  assign vrf_raddr_o[1] = vfu_pkg::vreg_addr_t'(req_i.vs1 * WPR + word_cnt_q);

  ////////////////////////////////////////
  // Operands and tag
  ////////////////////////////////////////

  always_comb begin
    // Scalars run at full lane width
    issue.op   = req_i.op;
    issue.vsew = req_i.is_scalar ? vfu_pkg::EW_32 : req_i.vsew;

    if (req_i.is_scalar) begin
      issue.op1 = {(BPW/4){req_i.rs1}};
      issue.op2 = {(BPW/4){req_i.rs2}};
    end else begin
      issue.op2 = vrf_rdata_i[0];
      if (req_i.use_vs1) begin
        issue.op1 = vrf_rdata_i[1];
      end else begin
        // rs1 replicated at the element width
        unique case (req_i.vsew)
          vfu_pkg::EW_8:  issue.op1 = {BPW{req_i.rs1[7:0]}};
          vfu_pkg::EW_16: issue.op1 = {(BPW/2){req_i.rs1[15:0]}};
          default:        issue.op1 = {(BPW/4){req_i.rs1}};
        endcase
      end
    end

    issue.tag.id      = req_i.id;
    issue.tag.rd      = req_i.rd;
    issue.tag.vd_addr = vfu_pkg::vreg_addr_t'(req_i.vd * WPR + word_cnt_q);
    issue.tag.be      = (last_word && !req_i.is_scalar) ? tail_be : '1;
    issue.tag.wb      = req_i.is_scalar;
    issue.tag.last    = last_word;
  end

  vl_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && !req_i.is_scalar |-> req_i.vl != '0);

  vl_fits: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && !req_i.is_scalar |-> int'(total_bytes) <= BPW * WPR);

endmodule

// ==== design/vfu_writeback.sv ====
/*
  Register file write port and instruction responses.
  A last vector word writes and responds in the same cycle.
  Scalar words only respond, with lane 0 as the result.
*/

`timescale 1ns/100ps

module vfu_writeback (
  input  logic                clk_i,
  input  logic                rst_n_i,
  vfu_result_if.sink          result,
  output vfu_pkg::vreg_addr_t vrf_waddr_o,
  output vfu_pkg::vreg_data_t vrf_wdata_o,
  output logic                vrf_we_o,
  output vfu_pkg::vreg_be_t   vrf_wbe_o,
  input  logic                vrf_wvalid_i,
  output vfu_pkg::vfu_rsp_t   rsp_o,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i
);

  logic is_scalar;
  logic is_last;

  assign is_scalar = result.tag.wb;
  assign is_last   = result.tag.last;

  // Last word waits for both sides so write and response leave together
  assign vrf_we_o    = result.valid && !is_scalar && (!is_last || rsp_ready_i);
  assign rsp_valid_o = result.valid && (is_scalar || (is_last && vrf_wvalid_i));

  assign result.ready = is_scalar ? rsp_ready_i
                                  : (vrf_wvalid_i && (!is_last || rsp_ready_i));

  assign vrf_waddr_o = result.tag.vd_addr;
  assign vrf_wdata_o = result.result;
  assign vrf_wbe_o   = result.tag.be;

  assign rsp_o.id     = result.tag.id;
  assign rsp_o.rd     = result.tag.rd;
  assign rsp_o.wb     = is_scalar;
  assign rsp_o.result = is_scalar ? result.result[31:0] : '0;

  // A scalar word is the whole instruction
  scalar_is_last: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    result.valid && is_scalar |-> is_last);

  // Lanes keep a stalled word in place
  result_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    result.valid && !result.ready |=> result.valid && $stable(result.tag));

endmodule

// ==== design/vfu_top.sv ====
/*
  Integer vector functional unit.
  One response per request, in request order.
  Vector length zero is not supported.
*/

`timescale 1ns/100ps

module vfu_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Request
  input  vfu_pkg::vfu_req_t         req_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  // Response
  output vfu_pkg::vfu_rsp_t         rsp_o,
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  // Register file reads, index 0 is vs2, index 1 is vs1
  output vfu_pkg::vreg_addr_t [1:0] vrf_raddr_o,
  output logic                [1:0] vrf_re_o,
  input  vfu_pkg::vreg_data_t [1:0] vrf_rdata_i,
  input  logic                [1:0] vrf_rvalid_i,
  // Register file write
  output vfu_pkg::vreg_addr_t       vrf_waddr_o,
  output vfu_pkg::vreg_data_t       vrf_wdata_o,
  output logic                      vrf_we_o,
  output vfu_pkg::vreg_be_t         vrf_wbe_o,
  input  logic                      vrf_wvalid_i
);

  vfu_pkg::vfu_req_t req_q;
  logic              req_q_valid;
  logic              req_q_ready;

  vfu_issue_if  issue_bus ();
  vfu_result_if result_bus ();

  spill_register #(
    .T(vfu_pkg::vfu_req_t)
  ) i_req_queue (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(req_valid_i),
    .ready_o(req_ready_o),
    .data_i (req_i),
    .valid_o(req_q_valid),
    .ready_i(req_q_ready),
    .data_o (req_q)
  );

  vfu_controller i_controller (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_q),
    .req_valid_i (req_q_valid),
    .req_ready_o (req_q_ready),
    .vrf_raddr_o (vrf_raddr_o),
    .vrf_re_o    (vrf_re_o),
    .vrf_rdata_i (vrf_rdata_i),
    .vrf_rvalid_i(vrf_rvalid_i),
    .issue       (issue_bus.issue)
  );

  int_lanes i_int_lanes (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .issue  (issue_bus.lane),
    .result (result_bus.source)
  );

  vfu_writeback i_writeback (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .result      (result_bus.sink),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_we_o    (vrf_we_o),
    .vrf_wbe_o   (vrf_wbe_o),
    .vrf_wvalid_i(vrf_wvalid_i),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

endmodule

// ==== verification/vrf_model.sv ====
/*
  Behavioral vector register file for the testbench.
  Reads and writes stall at random while stall_en_i is high.
  Keeps a golden copy and the expected writes and responses in request order.
  Test sources must never be written while a request is in flight.
*/

`timescale 1ns/100ps
`include "vfu_settings.svh"

module vrf_model (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      stall_en_i,
  input  vfu_pkg::vreg_addr_t [1:0] raddr_i,
  input  logic                [1:0] re_i,
  output vfu_pkg::vreg_data_t [1:0] rdata_o,
  output logic                [1:0] rvalid_o,
  input  vfu_pkg::vreg_addr_t       waddr_i,
  input  vfu_pkg::vreg_data_t       wdata_i,
  input  logic                      we_i,
  input  vfu_pkg::vreg_be_t         wbe_i,
  output logic                      wvalid_o,
  input  vfu_pkg::vfu_req_t         req_i,
  input  logic                      req_fire_i,
  input  logic                      rsp_fire_i,
  output vfu_pkg::vreg_addr_t       exp_waddr_o,
  output vfu_pkg::vreg_data_t       exp_wdata_o,
  output vfu_pkg::vreg_be_t         exp_wbe_o,
  output int                        exp_wr_cnt_o,
  output vfu_pkg::vfu_rsp_t         exp_rsp_o,
  output int                        exp_rsp_cnt_o
);

  localparam int WPR   = `VFU_WORDS_PER_VREG;
  localparam int DEPTH = `VFU_NR_VREGS * WPR;
  localparam int BPW   = `VFU_N_LANES * `VFU_ELEN / 8;

  typedef struct packed {
    vfu_pkg::vreg_addr_t addr;
    vfu_pkg::vreg_data_t data;
    vfu_pkg::vreg_be_t   be;
  } wr_t;

  vfu_pkg::vreg_data_t mem [DEPTH];
  vfu_pkg::vreg_data_t golden [DEPTH];
  wr_t                 wr_q [$];
  vfu_pkg::vfu_rsp_t   rsp_q [$];
  logic [1:0]          rd_ok;
  int                  seed = 32'h02d4e452;

  // One element at width w with operands sign extended from w bits
  function automatic logic [31:0] elem_op(vfu_pkg::vfu_op_e op, logic [31:0] a,
                                          logic [31:0] b, int w);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [31:0]        r;
    sa = $signed(a << (32 - w)) >>> (32 - w);
    sb = $signed(b << (32 - w)) >>> (32 - w);
    case (op)
      vfu_pkg::VADD: r = a + b;
      vfu_pkg::VSUB: r = a - b;
      vfu_pkg::VAND: r = a & b;
      vfu_pkg::VOR:  r = a | b;
      vfu_pkg::VXOR: r = a ^ b;
      vfu_pkg::VMIN: r = (sa < sb) ? a : b;
      default:       r = (sa > sb) ? a : b;
    endcase
    return (w == 32) ? r : (r & ((32'd1 << w) - 1));
  endfunction

  task automatic expect_vector(vfu_pkg::vfu_req_t r);
    int          sz;
    int          nbytes;
    int          base;
    wr_t         w;
    logic [31:0] a;
    logic [31:0] b;
    sz     = 1 << r.vsew;
    nbytes = int'(r.vl) * sz;
    for (int k = 0; k < (nbytes + BPW - 1) / BPW; k++) begin
      w.addr = vfu_pkg::vreg_addr_t'(r.vd * WPR + k);
      w.data = '0;
      w.be   = '0;
      for (int e = 0; e < BPW / sz; e++) begin
        base = k * BPW + e * sz;
        if (base < nbytes) begin
          b = 32'(golden[r.vs2 * WPR + k] >> (e * sz * 8));
          a = r.use_vs1 ? 32'(golden[r.vs1 * WPR + k] >> (e * sz * 8)) : r.rs1;
          w.data = w.data |
                   (vfu_pkg::vreg_data_t'(elem_op(r.op, a, b, sz * 8)) << (e * sz * 8));
          for (int j = 0; j < sz; j++) w.be[e * sz + j] = 1'b1;
        end
      end
      for (int j = 0; j < BPW; j++) begin
        if (w.be[j]) golden[w.addr][j*8 +: 8] = w.data[j*8 +: 8];
      end
      wr_q.push_back(w);
    end
  endtask

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i]    = {$random(seed), $random(seed)};
      golden[i] = mem[i];
    end
    rd_ok    = 2'b11;
    wvalid_o = 1'b1;
  end

  assign rdata_o[0] = mem[raddr_i[0]];
  assign rdata_o[1] = mem[raddr_i[1]];

  // A read is answered only while it is enabled
  assign rvalid_o = re_i & rd_ok;

  // Stall pattern, moved just after each edge like the other stimulus
  always @(posedge clk_i) begin
    #1;
    rd_ok[0] = !stall_en_i || ($random(seed) & 1);
    rd_ok[1] = !stall_en_i || ($random(seed) & 1);
    wvalid_o = !stall_en_i || (($random(seed) & 3) != 0);
  end

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (we_i && wvalid_o) begin
        for (int j = 0; j < BPW; j++) begin
          if (wbe_i[j]) mem[waddr_i][j*8 +: 8] = wdata_i[j*8 +: 8];
        end
        if (wr_q.size() != 0) void'(wr_q.pop_front());
      end
      if (rsp_fire_i && rsp_q.size() != 0) void'(rsp_q.pop_front());
      if (req_fire_i) begin
        if (!req_i.is_scalar) expect_vector(req_i);
        rsp_q.push_back(vfu_pkg::vfu_rsp_t'{id: req_i.id, rd: req_i.rd, wb: req_i.is_scalar,
                        result: req_i.is_scalar ? elem_op(req_i.op, req_i.rs1, req_i.rs2, 32)
                                                : 32'd0});
      end
    end
    exp_wr_cnt_o  <= wr_q.size();
    exp_waddr_o   <= (wr_q.size() != 0) ? wr_q[0].addr : '0;
    exp_wdata_o   <= (wr_q.size() != 0) ? wr_q[0].data : '0;
    exp_wbe_o     <= (wr_q.size() != 0) ? wr_q[0].be : '0;
    exp_rsp_cnt_o <= rsp_q.size();
    exp_rsp_o     <= (rsp_q.size() != 0) ? rsp_q[0] : '0;
  end

endmodule

// ==== verification/vfu_tb.sv ====
/*
  Testbench of the vector functional unit.
  Sources come from registers 0 to 15 and results go to 16 to 31,
  so requests in flight never depend on each other.
  Checks run on the falling edge, where all signals are settled.
*/

`timescale 1ns/100ps

module vfu_tb;

  localparam int TIMEOUT = 4000;

  logic                      clk_i = 1'b0;
  logic                      rst_n_i;
  vfu_pkg::vfu_req_t         req_i;
  logic                      req_valid_i;
  logic                      req_ready_o;
  vfu_pkg::vfu_rsp_t         rsp_o;
  logic                      rsp_valid_o;
  logic                      rsp_ready_i;
  vfu_pkg::vreg_addr_t [1:0] vrf_raddr;
  logic                [1:0] vrf_re;
  vfu_pkg::vreg_data_t [1:0] vrf_rdata;
  logic                [1:0] vrf_rvalid;
  vfu_pkg::vreg_addr_t       vrf_waddr;
  vfu_pkg::vreg_data_t       vrf_wdata;
  logic                      vrf_we;
  vfu_pkg::vreg_be_t         vrf_wbe;
  logic                      vrf_wvalid;

  vfu_pkg::vreg_addr_t exp_waddr;
  vfu_pkg::vreg_data_t exp_wdata;
  vfu_pkg::vreg_be_t   exp_wbe;
  int                  exp_wr_cnt;
  vfu_pkg::vfu_rsp_t   exp_rsp;
  int                  exp_rsp_cnt;

  int     seed = 32'h02d4e452;
  int     errors = 0;
  int     test_errors;
  int     tests_passed = 0;
  int     tests_failed = 0;
  string  test_name = "reset";
  logic   stall_en = 1'b0;
  logic   vs1_forbidden = 1'b0;
  logic   timed_out = 1'b0;
  logic [1:0] next_id = 2'd0;

  always #50 clk_i = !clk_i;

  vfu_top uut (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .req_i(req_i), .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
    .rsp_o(rsp_o), .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i),
    .vrf_raddr_o(vrf_raddr), .vrf_re_o(vrf_re),
    .vrf_rdata_i(vrf_rdata), .vrf_rvalid_i(vrf_rvalid),
    .vrf_waddr_o(vrf_waddr), .vrf_wdata_o(vrf_wdata), .vrf_we_o(vrf_we),
    .vrf_wbe_o(vrf_wbe), .vrf_wvalid_i(vrf_wvalid)
  );

  vrf_model u_vrf (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .stall_en_i(stall_en),
    .raddr_i(vrf_raddr), .re_i(vrf_re), .rdata_o(vrf_rdata), .rvalid_o(vrf_rvalid),
    .waddr_i(vrf_waddr), .wdata_i(vrf_wdata), .we_i(vrf_we), .wbe_i(vrf_wbe),
    .wvalid_o(vrf_wvalid),
    .req_i(req_i), .req_fire_i(req_valid_i && req_ready_o),
    .rsp_fire_i(rsp_valid_o && rsp_ready_i),
    .exp_waddr_o(exp_waddr), .exp_wdata_o(exp_wdata), .exp_wbe_o(exp_wbe),
    .exp_wr_cnt_o(exp_wr_cnt), .exp_rsp_o(exp_rsp), .exp_rsp_cnt_o(exp_rsp_cnt)
  );

  function automatic vfu_pkg::vreg_data_t be_mask(vfu_pkg::vreg_be_t be);
    vfu_pkg::vreg_data_t m;
    for (int j = 0; j < $bits(be); j++) m[j*8 +: 8] = {8{be[j]}};
    return m;
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  wr_expected: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    vrf_we && vrf_wvalid |-> exp_wr_cnt != 0)
    else begin
      $display("Unexpected register file write in test %s", test_name);
      errors++;
    end

  wr_addr: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    vrf_we && vrf_wvalid && exp_wr_cnt != 0 |-> vrf_waddr == exp_waddr)
    else begin
      $display("Mismatch %s waddr expected %h actual %h", test_name, exp_waddr, vrf_waddr);
      errors++;
    end

  wr_be: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    vrf_we && vrf_wvalid && exp_wr_cnt != 0 |-> vrf_wbe == exp_wbe)
    else begin
      $display("Mismatch %s wbe expected %h actual %h", test_name, exp_wbe, vrf_wbe);
      errors++;
    end

  wr_data: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    vrf_we && vrf_wvalid && exp_wr_cnt != 0 |-> (vrf_wdata & be_mask(exp_wbe)) == exp_wdata)
    else begin
      $display("Mismatch %s wdata expected %h actual %h", test_name, exp_wdata,
               vrf_wdata & be_mask(exp_wbe));
      errors++;
    end

  rsp_expected: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o && rsp_ready_i |-> exp_rsp_cnt != 0)
    else begin
      $display("Response without a pending request in test %s", test_name);
      errors++;
    end

  rsp_match: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o && rsp_ready_i && exp_rsp_cnt != 0 |-> rsp_o == exp_rsp)
    else begin
      $display("Mismatch %s response expected %h actual %h", test_name, exp_rsp, rsp_o);
      errors++;
    end

  no_vs1_read: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    vrf_re[1] |-> !vs1_forbidden)
    else begin
      $display("vs1 read enable raised in test %s", test_name);
      errors++;
    end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    #1;
    rsp_ready_i = !stall_en || (($random(seed) & 3) != 0);
  end

  task automatic finish_run();
    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  task automatic send_req(vfu_pkg::vfu_req_t r);
    int t;
    if (timed_out) return;
    t = 0;
    r.id        = next_id;
    next_id     = next_id + 1'b1;
    req_i       = r;
    req_valid_i = 1'b1;
    @(posedge clk_i);
    while (!req_ready_o && t < TIMEOUT) begin
      @(posedge clk_i);
      t++;
    end
    #1;
    req_valid_i = 1'b0;
    if (t >= TIMEOUT) begin
      $display("Timeout waiting for the request to be accepted in test %s", test_name);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // Random vector request with sources in the low half and vd in the high half
  task automatic build_vec(output vfu_pkg::vfu_req_t r, input int op, input int ew,
                           input logic use_vs1, input int vl);
    r         = '0;
    r.op      = vfu_pkg::vfu_op_e'(op);
    r.vsew    = vfu_pkg::vew_e'(ew);
    r.vl      = vfu_pkg::vlen_t'(vl);
    r.vs1     = 5'($unsigned($random(seed)) % 16);
    r.vs2     = 5'($unsigned($random(seed)) % 16);
    r.vd      = 5'(16 + $unsigned($random(seed)) % 16);
    r.rs1     = $random(seed);
    r.use_vs1 = use_vs1;
    r.rd      = 5'($random(seed));
  endtask

  function automatic int rand_vl(int ew);
    return 1 + ($unsigned($random(seed)) % (32 >> ew));
  endfunction

  task automatic wait_idle();
    int t;
    if (timed_out) return;
    t = 0;
    while ((exp_rsp_cnt != 0 || exp_wr_cnt != 0) && t < TIMEOUT) begin
      @(posedge clk_i);
      t++;
    end
    repeat (2) @(posedge clk_i);
    #1;
    if (t >= TIMEOUT) begin
      $display("Timeout waiting for %0d responses in test %s", exp_rsp_cnt, test_name);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic end_test();
    for (int a = 0; a < 128; a++) begin
      assert (u_vrf.mem[a] == u_vrf.golden[a])
        else begin
          $display("Mismatch %s vreg word %0d expected %h actual %h", test_name, a,
                   u_vrf.golden[a], u_vrf.mem[a]);
          errors++;
        end
    end
    if (errors == test_errors) tests_passed++;
    else tests_failed++;
    $display("Test %s: %s", test_name, (errors == test_errors) ? "ok" : "failed");
    test_errors = errors;
  endtask

  task automatic run_tests();
    vfu_pkg::vfu_req_t r;

    test_name = "vector_vector";
    for (int op = 0; op < 7; op++) begin
      for (int ew = 0; ew < 3; ew++) begin
        build_vec(r, op, ew, 1'b1, rand_vl(ew));
        send_req(r);
      end
    end
    wait_idle();
    end_test();
    if (timed_out) return;

    test_name     = "vector_scalar";
    vs1_forbidden = 1'b1;
    for (int op = 0; op < 7; op++) begin
      for (int ew = 0; ew < 3; ew++) begin
        build_vec(r, op, ew, 1'b0, rand_vl(ew));
        send_req(r);
      end
    end
    wait_idle();
    vs1_forbidden = 1'b0;
    end_test();
    if (timed_out) return;

    // Every tail length at each width
    test_name = "tail";
    for (int ew = 0; ew < 3; ew++) begin
      for (int vl = 1; vl <= (32 >> ew); vl++) begin
        build_vec(r, 0, ew, 1'b1, vl);
        send_req(r);
      end
    end
    wait_idle();
    end_test();
    if (timed_out) return;

    test_name = "scalar";
    for (int op = 0; op < 7; op++) begin
      r           = '0;
      r.op        = vfu_pkg::vfu_op_e'(op);
      r.vl        = 1;
      r.rs1       = $random(seed);
      r.rs2       = $random(seed);
      r.is_scalar = 1'b1;
      r.rd        = 5'($random(seed));
      send_req(r);
    end
    wait_idle();
    end_test();
    if (timed_out) return;

    test_name = "backpressure";
    stall_en  = 1'b1;
    repeat (80) begin
      if (($random(seed) & 7) == 0) begin
        r           = '0;
        r.op        = vfu_pkg::vfu_op_e'($unsigned($random(seed)) % 7);
        r.vl        = 1;
        r.rs1       = $random(seed);
        r.rs2       = $random(seed);
        r.is_scalar = 1'b1;
        r.rd        = 5'($random(seed));
      end else begin
        build_vec(r, $unsigned($random(seed)) % 7, $unsigned($random(seed)) % 3,
                  1'($random(seed)), 0);
        r.vl = vfu_pkg::vlen_t'(rand_vl(int'(r.vsew)));
      end
      send_req(r);
    end
    wait_idle();
    stall_en = 1'b0;
    end_test();
  endtask

  initial begin
    rst_n_i     = 1'b0;
    req_i       = '0;
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b1;
    test_errors = 0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    run_tests();
    finish_run();
  end

endmodule

// ==== list.f ====
+incdir+common
common/vfu_pkg.sv
common/vfu_if.sv
design/spill_register.sv
int_lanes/int_lanes.sv
design/vfu_controller.sv
design/vfu_writeback.sv
design/vfu_top.sv
verification/vrf_model.sv
verification/vfu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the vector functional unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module vfu_tb -o vfu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vfu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
